//--- all.f
verilog/pong_pkg.sv
verilog/speed_divider.sv
verilog/peer_reg_bank.sv
verilog/game_controller_for_two.sv
verilog/pong_top.sv
dv/tb_clock.sv
dv/pong_tb_sva.sv
dv/pong_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run pong_tb"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pong_tb -o pong_sim
	./obj_dir/pong_sim | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/pong_tb.sv
`timescale 1ns/1ps

module pong_tb
    import pong_pkg::*;
;

    localparam int BASE_PERIOD = 54;

    typedef struct packed {
        int y;
        int vel;
        int grav;
    } ball_model_t;

    logic       clk_25MHZ;
    logic       reset;
    logic [7:0] paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    logic       pready;
    logic       game_start;
    logic       collision_detected;
    logic       upscale;
    logic [9:0] estimated_speed;
    logic       master_done;
    logic [9:0] ball_x;
    logic [9:0] ball_y;
    logic       ball_send_trigger;
    logic       game_over;
    logic       is_you_win;
    logic       is_idle;
    logic       moving_left;
    logic       moving_right;

    int          errors;
    int          timeouts;
    logic [15:0] lfsr;

    tb_clock i_tb_clock (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset)
    );

    pong_top #(
        .BASE_PERIOD(BASE_PERIOD)
    ) i_pong_top (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .paddr              (paddr),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .game_start         (game_start),
        .collision_detected (collision_detected),
        .upscale            (upscale),
        .estimated_speed    (estimated_speed),
        .master_done        (master_done),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .ball_send_trigger  (ball_send_trigger),
        .game_over          (game_over),
        .is_you_win         (is_you_win),
        .is_idle            (is_idle),
        .moving_left        (moving_left),
        .moving_right       (moving_right)
    );

    bind pong_top pong_tb_sva i_pong_tb_sva (
        .clk_25MHZ         (clk_25MHZ),
        .reset             (reset),
        .psel              (psel),
        .penable           (penable),
        .game_start        (game_start),
        .master_done       (master_done),
        .ball_send_trigger (ball_send_trigger)
    );

    // One vertical step of the ball, gravity before the wall test.
    function automatic ball_model_t ref_step(ball_model_t b, int y_max);
        ball_model_t n;
        int          sum;
        sum    = b.y + b.vel;
        n.vel  = (b.grav == 3) ? b.vel + 1 : b.vel;
        n.y    = sum;
        n.grav = (b.grav + 1) % 4;
        if (sum >= y_max) begin
            n.y   = y_max;
            n.vel = -n.vel;
        end else if (sum <= 0) begin
            n.y   = 0;
            n.vel = -n.vel;
        end
        return n;
    endfunction

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1.
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic compare(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk_25MHZ);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk_25MHZ);
        penable <= 1'b1;
        @(posedge clk_25MHZ);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
        @(posedge clk_25MHZ);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk_25MHZ);
        penable <= 1'b1;
        @(negedge clk_25MHZ);
        data = prdata;
        compare("pready", pready, 1);
        @(posedge clk_25MHZ);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic pulse_game_start();
        @(posedge clk_25MHZ);
        game_start <= 1'b1;
        @(posedge clk_25MHZ);
        game_start <= 1'b0;
    endtask

    task automatic pulse_master_done();
        @(posedge clk_25MHZ);
        master_done <= 1'b1;
        @(posedge clk_25MHZ);
        master_done <= 1'b0;
    endtask

    task automatic pulse_collision(input logic [9:0] speed);
        @(posedge clk_25MHZ);
        collision_detected <= 1'b1;
        estimated_speed    <= speed;
        @(posedge clk_25MHZ);
        collision_detected <= 1'b0;
    endtask

    function automatic logic flag_value(input int which);
        case (which)
            0:       return ball_send_trigger;
            1:       return game_over;
            2:       return i_pong_top.div_done;
            3:       return moving_right;
            4:       return moving_left;
            5:       return ball_x == X_RETURN;
            6:       return 3'(i_pong_top.i_game_controller.state) == 3'd0;
            default: return is_you_win;
        endcase
    endfunction

    task automatic wait_flag(input int which, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk_25MHZ);
        while (!flag_value(which) && n < limit) begin
            @(negedge clk_25MHZ);
            n++;
        end
        if (!flag_value(which)) begin
            timeouts++;
            $display("Timeout at %0t ns while waiting for %s", $time, what);
        end
    endtask

    // Counts clocks until ball_x moves away from its current value.
    task automatic wait_x_change(input int limit, output int clocks);
        logic [9:0] last;
        last   = ball_x;
        clocks = 0;
        do begin
            @(negedge clk_25MHZ);
            clocks++;
        end while (ball_x == last && clocks < limit);
        if (ball_x == last) begin
            timeouts++;
            $display("Timeout at %0t ns, ball_x stayed at %0d", $time, last);
        end
    endtask

    initial begin
        ball_model_t m;
        int          prev_x;
        int          clocks;
        int          speed;
        int          y_rx;
        int          v;
        int          n;
        logic [7:0]  rd;

        errors             = 0;
        timeouts           = 0;
        lfsr               = 16'd22;
        paddr              <= '0;
        psel               <= 1'b0;
        penable            <= 1'b0;
        pwrite             <= 1'b0;
        pwdata             <= '0;
        game_start         <= 1'b0;
        collision_detected <= 1'b0;
        upscale            <= 1'b0;
        estimated_speed    <= '0;
        master_done        <= 1'b0;

        n = 0;
        do begin
            @(negedge clk_25MHZ);
            n++;
        end while (reset !== 1'b0 && n < 20);
        if (reset !== 1'b0) begin
            timeouts++;
            $display("Timeout at %0t ns, reset was never released", $time);
        end
        compare("reset ball_x", ball_x, 0);
        compare("reset ball_y", ball_y, 220);
        compare("reset is_idle", is_idle, 1);
        compare("reset game_over", game_over, 0);
        compare("reset ball_send_trigger", ball_send_trigger, 0);

        // Serve to the right edge and hand off.
        m      = '{y: 220, vel: -3, grav: 0};
        prev_x = 0;
        pulse_game_start();
        while (prev_x < 300 && timeouts == 0) begin
            wait_x_change(200, clocks);
            compare("serve ball_x", ball_x, prev_x + 10);
            m = ref_step(m, 239);
            compare("serve ball_y", ball_y, m.y);
            compare("serve moving_right", moving_right, 1);
            prev_x = ball_x;
        end
        wait_flag(0, 100, "ball_send_trigger");
        apb_read(REG_TX_VY, rd);
        compare("REG_TX_VY", int'($signed(rd)), m.vel);
        apb_read(REG_TX_Y, rd);
        compare("REG_TX_Y", rd, m.y % 256);

        // New serve, then a collision with a random speed.
        pulse_game_start();
        pulse_game_start();
        wait_flag(3, 20, "moving_right");
        take_bits(3, speed);
        speed = speed + 2;  // Speeds 2 to 9.
        pulse_collision(10'(speed));
        wait_flag(2, 100, "div_done");
        wait_x_change(200, clocks);
        wait_x_change(200, clocks);
        compare("step interval", clocks, BASE_PERIOD / speed + 1);
        wait_flag(0, 20000, "ball_send_trigger after speed change");
        pulse_master_done();

        // Returned ball that is missed.
        take_bits(7, y_rx);
        y_rx = y_rx + 60;
        apb_write(REG_Y_HI, 8'(y_rx >> 8));
        apb_write(REG_Y_LO, 8'(y_rx));
        apb_write(REG_YSPEED, 8'd2);
        apb_write(REG_GRAVITY, 8'd0);
        apb_write(REG_SPEED, 8'd1);
        apb_write(REG_WIN, 8'd0);
        apb_write(REG_CTRL, 8'd1);
        wait_flag(5, 50, "ball at x 620");
        compare("received ball_y", ball_y, y_rx);
        apb_write(REG_CTRL, 8'd0);
        wait_flag(1, 10000, "game_over");
        compare("missed ball_x", ball_x, 0);
        compare("missed moving_left", moving_left, 0);

        // Back to a send, then the peer reports a win.
        apb_write(REG_CTRL, 8'd1);
        apb_write(REG_CTRL, 8'd0);
        wait_flag(4, 50, "moving_left");
        pulse_collision(10'd1);
        wait_flag(0, 200, "ball_send_trigger before win");
        pulse_master_done();
        apb_write(REG_WIN, 8'd1);
        apb_write(REG_CTRL, 8'd1);
        wait_flag(7, 50, "is_you_win");
        apb_write(REG_CTRL, 8'd0);
        wait_flag(6, 50, "idle state");
        compare("win is_you_win", is_you_win, 1);
        compare("win is_idle", is_idle, 1);

        // Readback of every writable register.
        for (int a = 0; a <= 8'h18; a += 4) begin
            take_bits(8, v);
            apb_write(8'(a), 8'(v));
            apb_read(8'(a), rd);
            compare($sformatf("readback 0x%02h", a), rd, v);
        end

        $display("Done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/pong_tb_sva.sv
`timescale 1ns/1ps

module pong_tb_sva (
    input logic clk_25MHZ,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic game_start,
    input logic master_done,
    input logic ball_send_trigger
);

    // Access phase only follows a selected setup phase.
    penable_needs_psel: assert property (@(posedge clk_25MHZ) disable iff (reset)
        penable |-> psel)
        else $error("APB penable high without psel");

    setup_then_access: assert property (@(posedge clk_25MHZ) disable iff (reset)
        psel && !penable |=> psel && penable)
        else $error("APB setup phase not followed by access phase");

    // Trigger stays up until the link answers.
    trigger_held: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball_send_trigger && !master_done && !game_start |=> ball_send_trigger)
        else $error("ball_send_trigger dropped before master_done");

    trigger_released: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball_send_trigger && master_done |=> !ball_send_trigger)
        else $error("ball_send_trigger still high after master_done");

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_25MHZ,
    output logic reset
);

    initial begin
        clk_25MHZ = 1'b0;
        forever #20 clk_25MHZ = ~clk_25MHZ;  // 40 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk_25MHZ);
        reset <= 1'b0;
    end

endmodule

//--- verilog/pong_top.sv
`timescale 1ns/1ps

module pong_top
    import pong_pkg::*;
#(
    parameter int BASE_PERIOD = 270000
) (
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic [7:0] paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] pwdata,
    output logic [7:0] prdata,
    output logic       pready,
    input  logic       game_start,
    input  logic       collision_detected,
    input  logic       upscale,
    input  logic [9:0] estimated_speed,
    input  logic       master_done,
    output logic [9:0] ball_x,
    output logic [9:0] ball_y,
    output logic       ball_send_trigger,
    output logic       game_over,
    output logic       is_you_win,
    output logic       is_idle,
    output logic       moving_left,
    output logic       moving_right
);

    ball_rx_t    rx;
    ball_tx_t    tx;
    logic        slave_done;
    logic        div_start;
    logic        div_done;
    logic [9:0]  div_divisor;
    logic [19:0] quotient;

    peer_reg_bank i_peer_reg_bank (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .rx         (rx),
        .slave_done (slave_done),
        .tx         (tx)
    );

    speed_divider #(
        .BASE_PERIOD(BASE_PERIOD)
    ) i_speed_divider (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .start     (div_start),
        .divisor   (div_divisor),
        .done      (div_done),
        .quotient  (quotient)
    );

    game_controller_for_two #(
        .BASE_PERIOD(BASE_PERIOD)
    ) i_game_controller (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .upscale            (upscale),
        .game_start         (game_start),
        .collision_detected (collision_detected),
        .estimated_speed    (estimated_speed),
        .rx                 (rx),
        .slave_done         (slave_done),
        .master_done        (master_done),
        .div_done           (div_done),
        .quotient           (quotient),
        .div_start          (div_start),
        .div_divisor        (div_divisor),
        .tx                 (tx),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .ball_send_trigger  (ball_send_trigger),
        .game_over          (game_over),
        .is_you_win         (is_you_win),
        .is_idle            (is_idle),
        .moving_left        (moving_left),
        .moving_right       (moving_right)
    );

endmodule

//--- verilog/game_controller_for_two.sv
`timescale 1ns/1ps

module game_controller_for_two
    import pong_pkg::*;
#(
    parameter int BASE_PERIOD = 270000
) (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic        game_start,
    input  logic        collision_detected,
    input  logic [9:0]  estimated_speed,
    input  ball_rx_t    rx,
    input  logic        slave_done,
    input  logic        master_done,
    input  logic        div_done,
    input  logic [19:0] quotient,
    output logic        div_start,
    output logic [9:0]  div_divisor,
    output ball_tx_t    tx,
    output logic [9:0]  ball_x,
    output logic [9:0]  ball_y,
    output logic        ball_send_trigger,
    output logic        game_over,
    output logic        is_you_win,
    output logic        is_idle,
    output logic        moving_left,
    output logic        moving_right
);

    localparam logic [19:0] PERIOD_FULL = 20'(BASE_PERIOD);
    localparam logic [19:0] PERIOD_HALF = 20'(BASE_PERIOD / 2);

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        WIN_FLAG,
        WAIT_WIN_FLAG,
        RUNNING_RIGHT,
        RUNNING_LEFT,
        STOP,
        SEND_BALL
    } state_t;

    state_t state, state_next;

    logic [9:0]        ball_x_next, ball_y_next;
    logic signed [7:0] ball_vel, ball_vel_next;
    logic [1:0]        grav, grav_next;
    logic [19:0]       counter, counter_next;
    logic [19:0]       period, period_next;
    logic              game_over_next;
    logic              send_next;
    logic              win_next;
    logic              load_rx;

    logic [9:0]         y_max;
    logic [9:0]         x_edge;
    logic               step;
    logic signed [11:0] y_sum;
    logic [9:0]         y_step;
    logic signed [7:0]  vel_step;
    logic               speed_hit;
    logic [9:0]         safe_speed;

    assign y_max  = upscale ? Y_MAX_HI : Y_MAX_LO;
    assign x_edge = (upscale ? WIDTH_HI : WIDTH_LO) - EDGE_MARGIN;
    assign step   = counter >= period;

    assign speed_hit  = collision_detected && (state == RUNNING_RIGHT);
    assign safe_speed = (estimated_speed < 10'd2) ? 10'd1 : estimated_speed;

    assign tx = '{y: ball_y, vy: ball_vel, gravity: grav, send: ball_send_trigger};

    // Vertical motion shared by both directions.
    always_comb begin
        y_sum    = $signed({2'b00, ball_y}) + 12'(ball_vel);
        vel_step = (grav == 2'd3) ? ball_vel + 8'sd1 : ball_vel;  // Gravity.
        y_step   = y_sum[9:0];
        if (y_sum >= $signed({2'b00, y_max})) begin
            y_step   = y_max;
            vel_step = -vel_step;
        end else if (y_sum <= 12'sd0) begin
            y_step   = '0;
            vel_step = -vel_step;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state             <= IDLE;
            ball_x            <= '0;
            ball_y            <= Y_START;
            ball_vel          <= Y_VEL_START;
            grav              <= '0;
            counter           <= '0;
            period            <= PERIOD_FULL;
            game_over         <= 1'b0;
            ball_send_trigger <= 1'b0;
            is_you_win        <= 1'b0;
            div_start         <= 1'b0;
        end else begin
            state             <= state_next;
            ball_x            <= ball_x_next;
            ball_y            <= ball_y_next;
            ball_vel          <= ball_vel_next;
            grav              <= grav_next;
            counter           <= counter_next;
            period            <= period_next;
            game_over         <= game_over_next;
            ball_send_trigger <= send_next;
            is_you_win        <= win_next;
            div_start         <= speed_hit;  // One clock per collision cycle.
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (speed_hit) begin
            div_divisor <= safe_speed;
        end
    end

    always_comb begin
        state_next     = state;
        ball_x_next    = ball_x;
        ball_y_next    = ball_y;
        ball_vel_next  = ball_vel;
        grav_next      = grav;
        counter_next   = counter;
        period_next    = div_done ? quotient : period;
        game_over_next = 1'b0;
        send_next      = 1'b0;
        win_next       = is_you_win;
        load_rx        = 1'b0;
        is_idle        = 1'b0;
        moving_left    = 1'b0;
        moving_right   = 1'b0;

        case (state)
            IDLE: begin
                is_idle       = 1'b1;
                ball_x_next   = '0;
                ball_y_next   = Y_START;
                ball_vel_next = Y_VEL_START;
                grav_next     = '0;
                counter_next  = '0;
                period_next   = PERIOD_FULL;
                if (game_start) begin
                    state_next = RUNNING_RIGHT;
                    win_next   = 1'b0;
                end
                if (slave_done) begin
                    state_next = WAIT;
                    load_rx    = 1'b1;
                end
            end

            WAIT: begin
                is_idle = 1'b1;
                if (!slave_done) begin
                    state_next = RUNNING_LEFT;
                end
            end

            WIN_FLAG: begin
                is_idle = 1'b1;  // Waits for a win report or a returned ball.
                if (!master_done && slave_done) begin
                    if (rx.win) begin
                        state_next = WAIT_WIN_FLAG;
                        win_next   = 1'b1;
                    end else begin
                        state_next = WAIT;
                        load_rx    = 1'b1;
                    end
                end
                if (game_start) begin
                    state_next = IDLE;
                end
            end

            WAIT_WIN_FLAG: begin
                is_idle = 1'b1;
                if (!slave_done) begin
                    state_next = IDLE;
                end
            end

            RUNNING_RIGHT: begin
                moving_right = 1'b1;
                if (ball_x >= x_edge) begin
                    state_next   = SEND_BALL;
                    counter_next = '0;
                end else if (step) begin
                    ball_x_next   = ball_x + X_STEP;
                    ball_y_next   = y_step;
                    ball_vel_next = vel_step;
                    grav_next     = grav + 2'd1;
                    counter_next  = '0;
                end else begin
                    counter_next = counter + 20'd1;
                end
            end

            RUNNING_LEFT: begin
                moving_left = 1'b1;
                if (collision_detected) begin
                    state_next   = RUNNING_RIGHT;
                    counter_next = '0;
                end else if (ball_x == '0) begin
                    state_next     = STOP;  // Missed the returned ball.
                    game_over_next = 1'b1;
                end else if (step) begin
                    ball_x_next   = ball_x - X_STEP;
                    ball_y_next   = y_step;
                    ball_vel_next = vel_step;
                    grav_next     = grav + 2'd1;
                    counter_next  = '0;
                end else begin
                    counter_next = counter + 20'd1;
                end
            end

            STOP: begin
                game_over_next = 1'b1;
                if (slave_done) begin
                    state_next     = IDLE;
                    game_over_next = 1'b0;
                end
            end

            SEND_BALL: begin
                send_next = 1'b1;  // Held until the link is done.
                if (game_start) begin
                    state_next = IDLE;
                    send_next  = 1'b0;
                end
                if (master_done) begin
                    state_next = WIN_FLAG;
                    send_next  = 1'b0;
                end
            end

            default: state_next = IDLE;
        endcase

        if (load_rx) begin
            ball_x_next   = X_RETURN;
            ball_y_next   = rx.y;
            ball_vel_next = rx.vy;
            grav_next     = rx.gravity;
            period_next   = rx.speed_sel ? PERIOD_FULL : PERIOD_HALF;
            counter_next  = '0;
            win_next      = 1'b0;
        end
    end

endmodule

//--- verilog/peer_reg_bank.sv
`timescale 1ns/1ps

module peer_reg_bank
    import pong_pkg::*;
(
    input  logic     clk_25MHZ,
    input  logic     reset,
    input  logic [7:0] paddr,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  logic [7:0] pwdata,
    output logic [7:0] prdata,
    output logic     pready,
    output ball_rx_t rx,
    output logic     slave_done,
    input  ball_tx_t tx
);

    logic [7:0] y_hi;
    logic [7:0] y_lo;
    logic [7:0] yspeed;
    logic [7:0] gravity;
    logic [7:0] speed;
    logic [7:0] win;
    logic [7:0] ctrl;
    logic       access;

    assign access = psel && penable;
    assign pready = 1'b1;  // No wait states.

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            y_hi    <= '0;
            y_lo    <= '0;
            yspeed  <= '0;
            gravity <= '0;
            speed   <= '0;
            win     <= '0;
            ctrl    <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                REG_Y_HI:    y_hi    <= pwdata;
                REG_Y_LO:    y_lo    <= pwdata;
                REG_YSPEED:  yspeed  <= pwdata;
                REG_GRAVITY: gravity <= pwdata;
                REG_SPEED:   speed   <= pwdata;
                REG_WIN:     win     <= pwdata;
                REG_CTRL:    ctrl    <= pwdata;
                default: ;             // Status registers are read only.
            endcase
        end
    end

    assign rx = '{
        y:         {y_hi[1:0], y_lo},
        vy:        yspeed,
        gravity:   gravity[1:0],
        speed_sel: speed[0],
        win:       win[0]
    };
    assign slave_done = ctrl[0];

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_Y_HI:    prdata = y_hi;
                REG_Y_LO:    prdata = y_lo;
                REG_YSPEED:  prdata = yspeed;
                REG_GRAVITY: prdata = gravity;
                REG_SPEED:   prdata = speed;
                REG_WIN:     prdata = win;
                REG_CTRL:    prdata = ctrl;
                REG_TX_Y:    prdata = tx.y[7:0];
                REG_TX_VY:   prdata = tx.vy;
                REG_TX_STAT: prdata = {tx.send, 3'b000, tx.gravity, tx.y[9:8]};
                default:     prdata = '0;
            endcase
        end
    end

endmodule

//--- verilog/speed_divider.sv
`timescale 1ns/1ps

module speed_divider #(
    parameter int BASE_PERIOD = 270000
) (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        start,
    input  logic [9:0]  divisor,
    output logic        done,
    output logic [19:0] quotient
);

    localparam logic [19:0] DIVIDEND = 20'(BASE_PERIOD);

    logic        busy;
    logic [4:0]  count;
    logic [9:0]  rem;
    logic [9:0]  dsr;
    logic [19:0] work;      // Dividend bits out, quotient bits in.
    logic [10:0] trial;
    logic [10:0] diff;
    logic        fits;

    assign trial = {rem, work[19]};
    assign diff  = trial - {1'b0, dsr};
    assign fits  = trial >= {1'b0, dsr};

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;   // Restarts a running division too.
                count <= 5'd19;
            end else if (busy) begin
                if (count == 5'd0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    count <= count - 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (start) begin
            rem  <= '0;
            work <= DIVIDEND;
            dsr  <= divisor;
        end else if (busy) begin
            rem  <= fits ? diff[9:0] : trial[9:0];
            work <= {work[18:0], fits};
            if (count == 5'd0) begin
                quotient <= {work[18:0], fits};  // Held until the next result.
            end
        end
    end

endmodule

//--- verilog/pong_pkg.sv
package pong_pkg;

    // Screen geometry in pixels.
    localparam logic [9:0] WIDTH_LO    = 10'd320;
    localparam logic [9:0] WIDTH_HI    = 10'd640;
    localparam logic [9:0] EDGE_MARGIN = 10'd20;
    localparam logic [9:0] Y_MAX_LO    = 10'd239;
    localparam logic [9:0] Y_MAX_HI    = 10'd479;

    // Ball motion.
    localparam logic [9:0]        X_STEP      = 10'd10;
    localparam logic [9:0]        Y_START     = 10'd220;
    localparam logic [9:0]        X_RETURN    = 10'd620;
    localparam logic signed [7:0] Y_VEL_START = -8'sd3;

    // APB byte addresses of the peer register bank.
    localparam logic [7:0] REG_Y_HI    = 8'h00;
    localparam logic [7:0] REG_Y_LO    = 8'h04;
    localparam logic [7:0] REG_YSPEED  = 8'h08;
    localparam logic [7:0] REG_GRAVITY = 8'h0C;
    localparam logic [7:0] REG_SPEED   = 8'h10;
    localparam logic [7:0] REG_WIN     = 8'h14;
    localparam logic [7:0] REG_CTRL    = 8'h18;
    localparam logic [7:0] REG_TX_Y    = 8'h1C;
    localparam logic [7:0] REG_TX_VY   = 8'h20;
    localparam logic [7:0] REG_TX_STAT = 8'h24;

    typedef struct packed {
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic [1:0]        gravity;
        logic              speed_sel;  // 1 full period, 0 half.
        logic              win;
    } ball_rx_t;

    typedef struct packed {
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic [1:0]        gravity;
        logic              send;
    } ball_tx_t;

endpackage
